/* sd_pkg.sv */
// ================================================
// Shared definitions for the SPI-mode SD host:
// response kinds, the received response word and
// frame length constants
// ================================================

package sd_pkg;

  // Response expected after a command
  typedef enum logic [1:0] {
    resp_r1      = 2'd0,
    resp_r3r7    = 2'd1,
    resp_r1b     = 2'd2,
    resp_r1_data = 2'd3
  } resp_kind_t;

  // Received response word, read either as a bare R1
  // or as a full R3/R7 with status on top
  typedef union packed {
    struct packed {
      logic [31:0] unused;
      logic [7:0]  status;
    } r1;
    struct packed {
      logic [7:0]  status;
      logic [31:0] payload;
    } r3r7;
  } sd_response_t;

  // Command frame: start bits, index, argument, CRC7, end bit
  localparam int cmd_frame_bits = 48;

  // Bits covered by the command CRC7
  localparam int cmd_crc_span = 40;

  // Response lengths in bits
  localparam int r1_bits = 8;
  localparam int r3r7_bits = 40;

  // Trailing CRC of a data block
  localparam int crc16_bits = 16;

  // Generator polynomials without the top term
  localparam logic [6:0] crc7_poly = 7'h09;
  localparam logic [15:0] crc16_poly = 16'h1021;

  // Serial CRC7 over the leading part of a command frame
  function automatic logic [6:0] crc7_of(input logic [cmd_crc_span-1:0] data);
    logic [6:0] crc;
    logic feedback;
    crc = '0;
    for (int i = cmd_crc_span - 1; i >= 0; i--) begin
      feedback = data[i] ^ crc[6];
      crc = {crc[5:0], 1'b0};
      if (feedback) begin
        crc = crc ^ crc7_poly;
      end
    end
    return crc;
  endfunction

endpackage

/* sd_cmd_sender.sv */
// ================================================
// SD command sender: frames index and argument
// with CRC7 and shifts the 48-bit frame onto mosi
// ================================================

`timescale 1ns/1ps

module sd_cmd_sender (
  input  logic        clock,
  input  logic        reset,
  input  logic        send_valid,
  input  logic [5:0]  send_index,
  input  logic [31:0] send_argument,
  output logic        send_ready,
  output logic        send_done,
  output logic        mosi
);

  localparam int frame_bits = sd_pkg::cmd_frame_bits;
  localparam int count_width = $clog2(frame_bits);

  logic [frame_bits-1:0] frame;
  logic [frame_bits-1:0] shift_reg;
  logic [count_width-1:0] bit_count;
  logic [6:0] crc7;
  logic busy;
  logic accept;

  // Start bits 01, index and argument feed the CRC
  always_comb begin
    crc7 = sd_pkg::crc7_of({2'b01, send_index, send_argument});
    frame = {2'b01, send_index, send_argument, crc7, 1'b1};
  end

  assign send_ready = !busy;
  assign accept = send_valid && send_ready;

  // Frame MSB goes out the cycle after acceptance
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy <= 1'b0;
      bit_count <= '0;
      send_done <= 1'b0;
      mosi <= 1'b1;
    end else begin
      send_done <= 1'b0;
      if (accept) begin
        busy <= 1'b1;
        bit_count <= count_width'(frame_bits - 1);
        mosi <= frame[frame_bits-1];
      end else if (busy) begin
        if (bit_count == '0) begin
          // Last bit was on the line this cycle
          busy <= 1'b0;
          send_done <= 1'b1;
          mosi <= 1'b1;
        end else begin
          bit_count <= bit_count - 1'b1;
          mosi <= shift_reg[frame_bits-1];
        end
      end
    end
  end

  // Remaining frame bits, refilled with ones
  always_ff @(posedge clock) begin
    if (accept) begin
      shift_reg <= {frame[frame_bits-2:0], 1'b1};
    end else if (busy) begin
      shift_reg <= {shift_reg[frame_bits-2:0], 1'b1};
    end
  end

endmodule

/* sd_resp_receiver.sv */
// ================================================
// SD response receiver: start bit search with
// timeout, R1, R3/R7 and data block capture,
// CRC16 check and busy wait for R1b
// ================================================

`timescale 1ns/1ps

module sd_resp_receiver #(
  parameter int block_bytes = 512,
  parameter int ncr_limit = 64
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     recv_valid,
  input  sd_pkg::resp_kind_t       recv_kind,
  input  logic                     miso,
  output logic                     recv_ready,
  output logic                     recv_done,
  output sd_pkg::sd_response_t     recv_word,
  output logic [block_bytes*8-1:0] recv_block,
  output logic                     recv_crc_error,
  output logic                     recv_timeout
);

  localparam int block_bits = block_bytes * 8;
  localparam int data_bits = block_bits + sd_pkg::crc16_bits;
  localparam int max_bits = (data_bits > sd_pkg::r3r7_bits) ? data_bits : sd_pkg::r3r7_bits;
  localparam int count_width = $clog2(max_bits + 1);
  localparam int wait_width = $clog2(ncr_limit + 1);

  localparam logic [1:0] state_idle = 2'd0;
  localparam logic [1:0] state_wait_start = 2'd1;
  localparam logic [1:0] state_receiving = 2'd2;
  localparam logic [1:0] state_wait_busy = 2'd3;

  logic [1:0] state;
  sd_pkg::resp_kind_t kind_q;
  logic [count_width-1:0] bit_count;
  logic [wait_width-1:0] wait_count;
  logic [15:0] crc16;
  logic [15:0] crc16_next;
  logic [sd_pkg::r3r7_bits-1:0] word_q;
  logic is_data;
  logic start_seen;

  assign recv_ready = (state == state_idle);
  assign is_data = (kind_q == sd_pkg::resp_r1_data);
  assign start_seen = (state == state_wait_start) && !miso;
  assign recv_word = word_q;

  // CRC16 LFSR step over the incoming bit
  always_comb begin
    crc16_next = {crc16[14:0], 1'b0};
    if (crc16[15] ^ miso) begin
      crc16_next = crc16_next ^ sd_pkg::crc16_poly;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= state_idle;
      kind_q <= sd_pkg::resp_r1;
      bit_count <= '0;
      wait_count <= '0;
      crc16 <= '0;
      recv_done <= 1'b0;
      recv_crc_error <= 1'b0;
      recv_timeout <= 1'b0;
    end else begin
      recv_done <= 1'b0;
      case (state)
        state_idle: begin
          if (recv_valid) begin
            kind_q <= recv_kind;
            wait_count <= '0;
            crc16 <= '0;
            recv_crc_error <= 1'b0;
            recv_timeout <= 1'b0;
            state <= state_wait_start;
          end
        end
        state_wait_start: begin
          if (!miso) begin
            // Responses: the zero is already their MSB
            if (is_data) begin
              bit_count <= count_width'(data_bits);
            end else if (kind_q == sd_pkg::resp_r3r7) begin
              bit_count <= count_width'(sd_pkg::r3r7_bits - 1);
            end else begin
              bit_count <= count_width'(sd_pkg::r1_bits - 1);
            end
            state <= state_receiving;
          end else if (wait_count == wait_width'(ncr_limit - 1)) begin
            recv_timeout <= 1'b1;
            recv_done <= 1'b1;
            state <= state_idle;
          end else begin
            wait_count <= wait_count + 1'b1;
          end
        end
        state_receiving: begin
          bit_count <= bit_count - 1'b1;
          if (is_data) begin
            crc16 <= crc16_next;
          end
          if (bit_count == count_width'(1)) begin
            if (is_data) begin
              recv_crc_error <= (crc16_next != 16'h0000);
            end
            if (kind_q == sd_pkg::resp_r1b) begin
              state <= state_wait_busy;
            end else begin
              recv_done <= 1'b1;
              state <= state_idle;
            end
          end
        end
        default: begin
          // Card holds miso low while busy
          if (miso) begin
            recv_done <= 1'b1;
            state <= state_idle;
          end
        end
      endcase
    end
  end

  // Response word, cleared per reception so an R1 lands in the low byte
  always_ff @(posedge clock) begin
    if (recv_ready && recv_valid) begin
      word_q <= '0;
    end else if ((start_seen || state == state_receiving) && !is_data) begin
      word_q <= {word_q[sd_pkg::r3r7_bits-2:0], miso};
    end
  end

  // Data bits only, CRC bits stay out of the block
  always_ff @(posedge clock) begin
    if (state == state_receiving && is_data &&
        bit_count > count_width'(sd_pkg::crc16_bits)) begin
      recv_block <= {recv_block[block_bits-2:0], miso};
    end
  end

endmodule

/* sd_transaction.sv */
// ================================================
// Client-facing transaction sequencer: command,
// response, optional data block, held result
// ================================================

`timescale 1ns/1ps

module sd_transaction #(
  parameter int block_bytes = 512
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     req_valid,
  input  logic [5:0]               req_index,
  input  logic [31:0]              req_argument,
  input  sd_pkg::resp_kind_t       req_kind,
  input  logic                     resp_ready,
  input  logic                     send_ready,
  input  logic                     send_done,
  input  logic                     recv_ready,
  input  logic                     recv_done,
  input  sd_pkg::sd_response_t     recv_word,
  input  logic [block_bytes*8-1:0] recv_block,
  input  logic                     recv_crc_error,
  input  logic                     recv_timeout,
  output logic                     req_ready,
  output logic                     resp_valid,
  output sd_pkg::sd_response_t     resp_word,
  output logic [block_bytes*8-1:0] resp_block,
  output logic                     resp_crc_error,
  output logic                     resp_timeout,
  output logic                     send_valid,
  output logic [5:0]               send_index,
  output logic [31:0]              send_argument,
  output logic                     recv_valid,
  output sd_pkg::resp_kind_t       recv_kind,
  output logic                     cs_n,
  output logic                     sclk_enable
);

  localparam logic [2:0] state_idle = 3'd0;
  localparam logic [2:0] state_send_cmd = 3'd1;
  localparam logic [2:0] state_wait_send = 3'd2;
  localparam logic [2:0] state_recv_resp = 3'd3;
  localparam logic [2:0] state_wait_resp = 3'd4;
  localparam logic [2:0] state_recv_data = 3'd5;
  localparam logic [2:0] state_wait_data = 3'd6;
  localparam logic [2:0] state_respond = 3'd7;

  logic [2:0] state;
  sd_pkg::resp_kind_t kind_q;
  logic data_follows;

  assign req_ready = (state == state_idle);
  assign send_valid = (state == state_send_cmd);
  assign recv_valid = (state == state_recv_resp) || (state == state_recv_data);
  assign sclk_enable = !cs_n;

  // A data read starts with a plain R1
  always_comb begin
    if (state == state_recv_data) begin
      recv_kind = sd_pkg::resp_r1_data;
    end else if (kind_q == sd_pkg::resp_r1_data) begin
      recv_kind = sd_pkg::resp_r1;
    end else begin
      recv_kind = kind_q;
    end
  end

  // Block follows only after a clean R1
  assign data_follows = (kind_q == sd_pkg::resp_r1_data) && !recv_timeout &&
                        (recv_word.r1.status == 8'h00);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= state_idle;
      kind_q <= sd_pkg::resp_r1;
      cs_n <= 1'b1;
      resp_valid <= 1'b0;
      resp_crc_error <= 1'b0;
      resp_timeout <= 1'b0;
    end else begin
      case (state)
        state_idle: begin
          if (req_valid) begin
            kind_q <= req_kind;
            cs_n <= 1'b0;
            state <= state_send_cmd;
          end
        end
        state_send_cmd: begin
          if (send_ready) state <= state_wait_send;
        end
        state_wait_send: begin
          if (send_done) state <= state_recv_resp;
        end
        state_recv_resp: begin
          if (recv_ready) state <= state_wait_resp;
        end
        state_wait_resp: begin
          if (recv_done) begin
            resp_timeout <= recv_timeout;
            resp_crc_error <= 1'b0;
            if (data_follows) begin
              state <= state_recv_data;
            end else begin
              resp_valid <= 1'b1;
              cs_n <= 1'b1;
              state <= state_respond;
            end
          end
        end
        state_recv_data: begin
          if (recv_ready) state <= state_wait_data;
        end
        state_wait_data: begin
          if (recv_done) begin
            resp_timeout <= recv_timeout;
            resp_crc_error <= recv_crc_error && !recv_timeout;
            resp_valid <= 1'b1;
            cs_n <= 1'b1;
            state <= state_respond;
          end
        end
        default: begin
          if (resp_ready) begin
            resp_valid <= 1'b0;
            state <= state_idle;
          end
        end
      endcase
    end
  end

  // Request fields and result payload
  always_ff @(posedge clock) begin
    if (req_ready && req_valid) begin
      send_index <= req_index;
      send_argument <= req_argument;
    end
    if (state == state_wait_resp && recv_done) begin
      resp_word <= recv_word;
    end
    if (state == state_wait_data && recv_done) begin
      resp_block <= recv_block;
    end
  end

endmodule

/* sd_spi_host.sv */
// ================================================
// SPI-mode SD host top level: sequencer, command
// sender and response receiver
// ================================================

`timescale 1ns/1ps

module sd_spi_host #(
  parameter int block_bytes = 512,
  parameter int ncr_limit = 64
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     req_valid,
  input  logic [5:0]               req_index,
  input  logic [31:0]              req_argument,
  input  sd_pkg::resp_kind_t       req_kind,
  input  logic                     resp_ready,
  input  logic                     miso,
  output logic                     req_ready,
  output logic                     resp_valid,
  output sd_pkg::sd_response_t     resp_word,
  output logic [block_bytes*8-1:0] resp_block,
  output logic                     resp_crc_error,
  output logic                     resp_timeout,
  output logic                     cs_n,
  output logic                     sclk_enable,
  output logic                     mosi
);

  logic send_valid;
  logic [5:0] send_index;
  logic [31:0] send_argument;
  logic send_ready;
  logic send_done;
  logic recv_valid;
  sd_pkg::resp_kind_t recv_kind;
  logic recv_ready;
  logic recv_done;
  sd_pkg::sd_response_t recv_word;
  logic [block_bytes*8-1:0] recv_block;
  logic recv_crc_error;
  logic recv_timeout;

  sd_transaction #(
    .block_bytes(block_bytes)
  ) transaction (
    .clock(clock),
    .reset(reset),
    .req_valid(req_valid),
    .req_index(req_index),
    .req_argument(req_argument),
    .req_kind(req_kind),
    .resp_ready(resp_ready),
    .send_ready(send_ready),
    .send_done(send_done),
    .recv_ready(recv_ready),
    .recv_done(recv_done),
    .recv_word(recv_word),
    .recv_block(recv_block),
    .recv_crc_error(recv_crc_error),
    .recv_timeout(recv_timeout),
    .req_ready(req_ready),
    .resp_valid(resp_valid),
    .resp_word(resp_word),
    .resp_block(resp_block),
    .resp_crc_error(resp_crc_error),
    .resp_timeout(resp_timeout),
    .send_valid(send_valid),
    .send_index(send_index),
    .send_argument(send_argument),
    .recv_valid(recv_valid),
    .recv_kind(recv_kind),
    .cs_n(cs_n),
    .sclk_enable(sclk_enable)
  );

  // Drives mosi
  sd_cmd_sender cmd_sender (
    .clock(clock),
    .reset(reset),
    .send_valid(send_valid),
    .send_index(send_index),
    .send_argument(send_argument),
    .send_ready(send_ready),
    .send_done(send_done),
    .mosi(mosi)
  );

  // Samples miso
  sd_resp_receiver #(
    .block_bytes(block_bytes),
    .ncr_limit(ncr_limit)
  ) resp_receiver (
    .clock(clock),
    .reset(reset),
    .recv_valid(recv_valid),
    .recv_kind(recv_kind),
    .miso(miso),
    .recv_ready(recv_ready),
    .recv_done(recv_done),
    .recv_word(recv_word),
    .recv_block(recv_block),
    .recv_crc_error(recv_crc_error),
    .recv_timeout(recv_timeout)
  );

endmodule

/* tb_sd_spi_host.sv */
// ==================================================
// Testbench for the SPI-mode SD host: behavioural
// card model, request sequence and result checks
// ==================================================

`timescale 1ns/1ps

module tb_sd_spi_host;

  localparam int block_bytes = 8;
  localparam int ncr_limit = 64;
  localparam int block_bits = block_bytes * 8;
  localparam int txn_total = 10;
  localparam int txn_cycles = 48 + ncr_limit + block_bits + 64;
  localparam int watchdog_cycles = 2 * txn_total * txn_cycles;

  logic clock;
  logic reset;
  logic req_valid;
  logic [5:0] req_index;
  logic [31:0] req_argument;
  sd_pkg::resp_kind_t req_kind;
  logic resp_ready;
  logic miso;
  logic req_ready;
  logic resp_valid;
  sd_pkg::sd_response_t resp_word;
  logic [block_bits-1:0] resp_block;
  logic resp_crc_error;
  logic resp_timeout;
  logic cs_n;
  logic sclk_enable;
  logic mosi;

  // Card behaviour for the running request
  sd_pkg::resp_kind_t card_kind;
  sd_pkg::sd_response_t card_word;
  logic [block_bits-1:0] card_block;
  logic card_silent;
  logic card_bad_crc;
  int card_busy_cycles;
  logic card_busy;
  logic [47:0] frame_q;
  logic frame_captured;

  // Expected result
  logic [5:0] exp_index;
  logic [31:0] exp_argument;
  logic exp_timeout;
  logic exp_crc_error;
  logic exp_block_valid;

  int seed = 32'hc9;
  int error_count;
  int frames_seen;
  int txn_count;

  sd_spi_host #(
    .block_bytes(block_bytes),
    .ncr_limit(ncr_limit)
  ) DUT (.*);

  initial clock = 1'b0;
  always #20 clock = ~clock;

  // x^7 + x^3 + 1, MSB first
  function automatic logic [6:0] frame_crc7(input logic [39:0] bits);
    logic [6:0] r;
    logic fb;
    r = 7'd0;
    for (int i = 39; i >= 0; i--) begin
      fb = r[6] ^ bits[i];
      r = {r[5:3], r[2] ^ fb, r[1:0], fb};
    end
    return r;
  endfunction

  // x^16 + x^12 + x^5 + 1 over the data bits only
  function automatic logic [15:0] block_crc16(input logic [block_bits-1:0] bits);
    logic [15:0] r;
    logic fb;
    r = 16'd0;
    for (int i = block_bits - 1; i >= 0; i--) begin
      fb = r[15] ^ bits[i];
      r = {r[14:12], r[11] ^ fb, r[10:5], r[4] ^ fb, r[3:0], fb};
    end
    return r;
  endfunction

  // One bit per clock, MSB first, line left high afterwards
  task automatic send_bits(input logic [87:0] bits, input int count);
    for (int i = count - 1; i >= 0; i--) begin
      miso = bits[i];
      @(posedge clock);
      #2;
    end
    miso = 1'b1;
  endtask

  task automatic answer_command();
    logic [15:0] crc;
    // Response delay stays well inside ncr_limit
    repeat (4 + $unsigned($random(seed)) % 8) @(posedge clock);
    #2;
    if (card_kind == sd_pkg::resp_r3r7) begin
      send_bits(88'(card_word), sd_pkg::r3r7_bits);
    end else begin
      send_bits(88'(card_word.r1.status), sd_pkg::r1_bits);
    end
    if (card_kind == sd_pkg::resp_r1b) begin
      card_busy = 1'b1;
      miso = 1'b0;
      repeat (card_busy_cycles) begin
        @(posedge clock);
        #2;
      end
      miso = 1'b1;
      card_busy = 1'b0;
    end else if (card_kind == sd_pkg::resp_r1_data && card_word.r1.status == 8'h00) begin
      repeat (2) begin
        @(posedge clock);
        #2;
      end
      crc = block_crc16(card_block) ^ {15'd0, card_bad_crc};
      send_bits({8'hFE, card_block, crc}, 88);
    end
  endtask

  // Card model: frame capture on the falling edge, where mosi is stable
  initial begin
    miso = 1'b1;
    card_busy = 1'b0;
    frame_captured = 1'b0;
    frames_seen = 0;
    forever begin
      @(negedge clock);
      if (!cs_n && !mosi) begin
        frame_q[47] = mosi;
        for (int i = 46; i >= 0; i--) begin
          @(negedge clock);
          frame_q[i] = mosi;
        end
        frames_seen++;
        frame_captured = 1'b1;
        @(negedge clock);
        frame_captured = 1'b0;
        if (!card_silent) begin
          answer_command();
        end
      end
    end
  end

  task automatic run_request(input sd_pkg::resp_kind_t kind, input logic [5:0] index,
                             input logic [31:0] argument, input logic [7:0] status,
                             input logic [31:0] payload, input logic silent,
                             input logic bad_crc);
    logic accepted;
    card_kind = kind;
    card_silent = silent;
    card_bad_crc = bad_crc;
    card_word = '0;
    if (kind == sd_pkg::resp_r3r7) begin
      card_word.r3r7.status = status;
      card_word.r3r7.payload = payload;
    end else begin
      card_word.r1.status = status;
    end
    card_block = {$random(seed), $random(seed)};
    card_busy_cycles = 3 + $unsigned($random(seed)) % 12;
    exp_index = index;
    exp_argument = argument;
    exp_timeout = silent;
    // A block only follows a clean R1
    exp_block_valid = !silent && kind == sd_pkg::resp_r1_data && status == 8'h00;
    exp_crc_error = exp_block_valid && bad_crc;
    req_valid = 1'b1;
    req_index = index;
    req_argument = argument;
    req_kind = kind;
    accepted = 1'b0;
    while (!accepted) begin
      accepted = req_ready;
      @(posedge clock);
      #2;
    end
    req_valid = 1'b0;
    while (!resp_valid) begin
      @(posedge clock);
      #2;
    end
    // Hold the result back for a few cycles
    repeat ($unsigned($random(seed)) % 6) begin
      @(posedge clock);
      #2;
    end
    resp_ready = 1'b1;
    @(posedge clock);
    #2;
    resp_ready = 1'b0;
    txn_count++;
  endtask

  initial begin
    reset = 1'b1;
    req_valid = 1'b0;
    req_index = '0;
    req_argument = '0;
    req_kind = sd_pkg::resp_r1;
    resp_ready = 1'b0;
    card_kind = sd_pkg::resp_r1;
    card_word = '0;
    card_block = '0;
    card_silent = 1'b0;
    card_bad_crc = 1'b0;
    card_busy_cycles = 0;
    exp_index = '0;
    exp_argument = '0;
    exp_timeout = 1'b0;
    exp_crc_error = 1'b0;
    exp_block_valid = 1'b0;
    error_count = 0;
    txn_count = 0;
    repeat (4) @(posedge clock);
    #2;
    reset = 1'b0;
    run_request(sd_pkg::resp_r1, 6'd0, 32'h0, 8'h01, 32'h0, 1'b0, 1'b0);
    run_request(sd_pkg::resp_r1, 6'd55, $random(seed), 8'h00, 32'h0, 1'b0, 1'b0);
    run_request(sd_pkg::resp_r3r7, 6'd8, 32'h1AA, 8'h01, 32'h1AA, 1'b0, 1'b0);
    run_request(sd_pkg::resp_r3r7, 6'd58, 32'h0, 8'h00, $random(seed), 1'b0, 1'b0);
    run_request(sd_pkg::resp_r1b, 6'd12, 32'h0, 8'h00, 32'h0, 1'b0, 1'b0);
    run_request(sd_pkg::resp_r1_data, 6'd17, $random(seed), 8'h00, 32'h0, 1'b0, 1'b0);
    run_request(sd_pkg::resp_r1_data, 6'd17, $random(seed), 8'h00, 32'h0, 1'b0, 1'b1);
    run_request(sd_pkg::resp_r1_data, 6'd17, 32'hFFFF_0000, 8'h04, 32'h0, 1'b0, 1'b0);
    run_request(sd_pkg::resp_r1, 6'd13, 32'h0, 8'h00, 32'h0, 1'b1, 1'b0);
    run_request(sd_pkg::resp_r1_data, 6'd17, 32'h200, 8'h00, 32'h0, 1'b1, 1'b0);
    repeat (4) @(posedge clock);
    if (frames_seen != txn_count) begin
      $display("Card model saw %0d command frames for %0d requests", frames_seen, txn_count);
      error_count++;
    end
    $display("Requests: %0d, frames: %0d, errors: %0d", txn_count, frames_seen, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("Watchdog expired: run did not finish within %0d cycles", watchdog_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

  frame_marker_check: assert property (@(posedge clock) disable iff (reset)
    frame_captured |-> frame_q[47:46] == 2'b01 && frame_q[0])
  else begin
    error_count++;
    $display("[FAIL] %0t mosi frame markers: got %b/%b, expected 01/1",
             $time, frame_q[47:46], frame_q[0]);
  end

  frame_index_check: assert property (@(posedge clock) disable iff (reset)
    frame_captured |-> frame_q[45:40] == exp_index)
  else begin
    error_count++;
    $display("[FAIL] %0t mosi index: got %0d, expected %0d", $time, frame_q[45:40], exp_index);
  end

  frame_argument_check: assert property (@(posedge clock) disable iff (reset)
    frame_captured |-> frame_q[39:8] == exp_argument)
  else begin
    error_count++;
    $display("[FAIL] %0t mosi argument: got %h, expected %h", $time, frame_q[39:8], exp_argument);
  end

  frame_crc_check: assert property (@(posedge clock) disable iff (reset)
    frame_captured |-> frame_q[7:1] == frame_crc7(frame_q[47:8]))
  else begin
    error_count++;
    $display("[FAIL] %0t mosi crc7: got %h, expected %h",
             $time, frame_q[7:1], frame_crc7(frame_q[47:8]));
  end

  timeout_check: assert property (@(posedge clock) disable iff (reset)
    $rose(resp_valid) |-> resp_timeout == exp_timeout)
  else begin
    error_count++;
    $display("[FAIL] %0t resp_timeout: got %b, expected %b", $time, resp_timeout, exp_timeout);
  end

  word_check: assert property (@(posedge clock) disable iff (reset)
    $rose(resp_valid) && !exp_timeout |-> resp_word == card_word)
  else begin
    error_count++;
    $display("[FAIL] %0t resp_word: got %h, expected %h", $time, resp_word, card_word);
  end

  block_check: assert property (@(posedge clock) disable iff (reset)
    $rose(resp_valid) && exp_block_valid |-> resp_block == card_block)
  else begin
    error_count++;
    $display("[FAIL] %0t resp_block: got %h, expected %h", $time, resp_block, card_block);
  end

  crc_error_check: assert property (@(posedge clock) disable iff (reset)
    $rose(resp_valid) |-> resp_crc_error == exp_crc_error)
  else begin
    error_count++;
    $display("[FAIL] %0t resp_crc_error: got %b, expected %b",
             $time, resp_crc_error, exp_crc_error);
  end

  busy_check: assert property (@(posedge clock) disable iff (reset)
    card_busy |-> !resp_valid)
  else begin
    error_count++;
    $display("[FAIL] %0t resp_valid: got 1, expected 0 while the card holds busy", $time);
  end

  hold_check: assert property (@(posedge clock) disable iff (reset)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_word) && $stable(resp_block) &&
    $stable(resp_crc_error) && $stable(resp_timeout))
  else begin
    error_count++;
    $display("Result outputs changed at %0t while resp_valid waited for resp_ready", $time);
  end

  // Bus idle while a result waits
  idle_check: assert property (@(posedge clock) disable iff (reset)
    resp_valid |-> cs_n && !req_ready)
  else begin
    error_count++;
    $display("[FAIL] %0t cs_n/req_ready: got %b/%b, expected 1/0", $time, cs_n, req_ready);
  end

  sclk_check: assert property (@(posedge clock) disable iff (reset)
    sclk_enable == !cs_n)
  else begin
    error_count++;
    $display("[FAIL] %0t sclk_enable: got %b, expected %b", $time, sclk_enable, !cs_n);
  end

endmodule

/* flist.f */
sd_pkg.sv
sd_cmd_sender.sv
sd_resp_receiver.sv
sd_transaction.sv
sd_spi_host.sv
tb_sd_spi_host.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --assert --timing -Wno-fatal
TOP       ?= tb_sd_spi_host
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_TEXT := STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
